// File: filelist.f
+incdir+source
source/adc_monitor_pkg.sv
source/cache_bus_if.sv
source/spi_adc_sampler.sv
source/peak_cache_arbiter.sv
source/uart_link.sv
source/peak_query_ctrl.sv
source/adc_monitor_top.sv
testbench/adc_monitor_assertions.sv
testbench/adc_monitor_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ADC peak monitor simulation with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module adc_monitor_tb -o adc_monitor_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/adc_monitor_sim > sim.log 2>&1
grep -q "TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: source/adc_monitor_defs.svh
// ADC peak monitor parameters for channel count, sample width, SPI framing and UART bit timing
`ifndef ADC_MONITOR_DEFS_SVH
`define ADC_MONITOR_DEFS_SVH

// Parallel serial ADCs sharing chip select and SPI clock
`define ADC_CHANNELS 4

// Width of one ADC sample and of a stored peak
`define SAMPLE_BITS 10

// SPI clocks with chip select low per frame
// two leading bits are ignored, then ten data bits MSB first
`define SPI_FRAME_CLKS 12

// clk cycles per half SPI clock
`define SPI_HALF_PERIOD 2

// SPI clocks with chip select high between frames
`define CS_IDLE_CLKS 4

// clk cycles per UART bit
`define UART_BIT_CLKS 16

`endif

// File: source/adc_monitor_pkg.sv
// ADC peak monitor types shared by the sampler, peak cache and query controller
`include "adc_monitor_defs.svh"

package adc_monitor_pkg;

    // One ADC sample, also used for a stored peak
    typedef logic [`SAMPLE_BITS-1:0] sample_t;

    // Channel index into the peak cache
    typedef logic [$clog2(`ADC_CHANNELS)-1:0] chan_t;

    // Operation requested from the peak cache
    //   CACHE_UPDATE keeps the larger of stored and written value
    //   CACHE_READ_CLEAR returns the stored value and zeroes it
    typedef enum logic {
        CACHE_UPDATE     = 1'b0,
        CACHE_READ_CLEAR = 1'b1
    } cache_op_e;

endpackage

// File: source/adc_monitor_top.sv
// Four-channel ADC peak monitor top level, SPI sampling and UART peak queries
`timescale 1ns/1ps
`include "adc_monitor_defs.svh"

module adc_monitor_top (
    input  logic                     clk,
    input  logic                     reset_b,
    input  logic [`ADC_CHANNELS-1:0] adc_miso,
    input  logic                     uart_rx,
    output logic                     adc_cs_n,
    output logic                     spi_sclk,
    output logic                     uart_tx
);

    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;

    // One cache bus per client
    cache_bus_if sampler_bus ();
    cache_bus_if query_bus ();

    spi_adc_sampler i_spi_adc_sampler (
        .clk      (clk),
        .reset_b  (reset_b),
        .adc_miso (adc_miso),
        .adc_cs_n (adc_cs_n),
        .spi_sclk (spi_sclk),
        .cache    (sampler_bus.client)
    );

    peak_cache_arbiter i_peak_cache_arbiter (
        .clk         (clk),
        .reset_b     (reset_b),
        .sampler_bus (sampler_bus.arbiter),
        .query_bus   (query_bus.arbiter)
    );

    peak_query_ctrl i_peak_query_ctrl (
        .clk      (clk),
        .reset_b  (reset_b),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .cache    (query_bus.client)
    );

    uart_link i_uart_link (
        .clk      (clk),
        .reset_b  (reset_b),
        .uart_rx  (uart_rx),
        .uart_tx  (uart_tx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy)
    );

endmodule

// File: source/cache_bus_if.sv
// Peak cache access bus between one client and the cache arbiter
`timescale 1ns/1ps

interface cache_bus_if;

    // Request side, held stable by the client until gnt
    logic                       req;
    adc_monitor_pkg::cache_op_e op;
    adc_monitor_pkg::chan_t     chan;
    adc_monitor_pkg::sample_t   wdata;

    // Response side
    logic                       gnt;
    adc_monitor_pkg::sample_t   rdata;
    logic                       rvalid;

    modport client (
        output req, op, chan, wdata,
        input  gnt, rdata, rvalid
    );

    modport arbiter (
        input  req, op, chan, wdata,
        output gnt, rdata, rvalid
    );

endinterface

// File: source/peak_cache_arbiter.sv
// Peak cache with round-robin arbitration between sampler and query clients
`timescale 1ns/1ps
`include "adc_monitor_defs.svh"

module peak_cache_arbiter (
    input  logic         clk,
    input  logic         reset_b,
    cache_bus_if.arbiter sampler_bus,
    cache_bus_if.arbiter query_bus
);

    logic                       prio_query;
    logic                       req_s;
    logic                       req_q;
    logic                       grant_s;
    logic                       grant_q;
    logic                       gnt_s_q;
    logic                       gnt_q_q;
    logic                       rvalid_s_q;
    logic                       rvalid_q_q;
    logic                       acc_valid;
    adc_monitor_pkg::cache_op_e acc_op;
    adc_monitor_pkg::chan_t     acc_chan;
    adc_monitor_pkg::sample_t   acc_wdata;
    adc_monitor_pkg::sample_t   rdata_q;
    adc_monitor_pkg::sample_t   peak_q [`ADC_CHANNELS];

    // A client already holding gnt is being served this cycle
    assign req_s = sampler_bus.req && !gnt_s_q;
    assign req_q = query_bus.req && !gnt_q_q;

    assign grant_s = req_s && (!req_q || !prio_query);
    assign grant_q = req_q && (!req_s || prio_query);

    // Access uses the granted client's held request
    assign acc_valid = gnt_s_q || gnt_q_q;
    assign acc_op    = gnt_s_q ? sampler_bus.op    : query_bus.op;
    assign acc_chan  = gnt_s_q ? sampler_bus.chan  : query_bus.chan;
    assign acc_wdata = gnt_s_q ? sampler_bus.wdata : query_bus.wdata;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            prio_query <= 1'b0;
            gnt_s_q    <= 1'b0;
            gnt_q_q    <= 1'b0;
            rvalid_s_q <= 1'b0;
            rvalid_q_q <= 1'b0;
            for (int ch = 0; ch < `ADC_CHANNELS; ch++) begin
                peak_q[ch] <= '0;
            end
        end else begin
            gnt_s_q <= grant_s;
            gnt_q_q <= grant_q;
            // Last winner loses priority
            if (grant_s) begin
                prio_query <= 1'b1;
            end else if (grant_q) begin
                prio_query <= 1'b0;
            end
            rvalid_s_q <= gnt_s_q && (acc_op == adc_monitor_pkg::CACHE_READ_CLEAR);
            rvalid_q_q <= gnt_q_q && (acc_op == adc_monitor_pkg::CACHE_READ_CLEAR);
            if (acc_valid) begin
                case (acc_op)
                    adc_monitor_pkg::CACHE_UPDATE: begin
                        if (acc_wdata > peak_q[acc_chan]) begin
                            peak_q[acc_chan] <= acc_wdata;
                        end
                    end
                    adc_monitor_pkg::CACHE_READ_CLEAR: begin
                        peak_q[acc_chan] <= '0;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Old value captured before the clear lands
    always_ff @(posedge clk) begin
        if (acc_valid && acc_op == adc_monitor_pkg::CACHE_READ_CLEAR) begin
            rdata_q <= peak_q[acc_chan];
        end
    end

    assign sampler_bus.gnt    = gnt_s_q;
    assign sampler_bus.rdata  = rdata_q;
    assign sampler_bus.rvalid = rvalid_s_q;
    assign query_bus.gnt      = gnt_q_q;
    assign query_bus.rdata    = rdata_q;
    assign query_bus.rvalid   = rvalid_q_q;

endmodule

// File: source/peak_query_ctrl.sv
// Query controller turning ASCII channel digits into a peak read-clear and two-byte reply
`timescale 1ns/1ps
`include "adc_monitor_defs.svh"

module peak_query_ctrl (
    input  logic        clk,
    input  logic        reset_b,
    input  logic [7:0]  rx_data,
    input  logic        rx_valid,
    output logic [7:0]  tx_data,
    output logic        tx_start,
    input  logic        tx_busy,
    cache_bus_if.client cache
);

    // ASCII '1'
    localparam logic [7:0] DIGIT_FIRST = 8'h31;
    localparam logic [7:0] DIGIT_LAST  = DIGIT_FIRST + 8'(`ADC_CHANNELS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_SEND_HI,
        ST_SEND_LO
    } state_e;

    state_e                   state;
    logic                     req_pending;
    logic                     tx_busy_d;
    logic                     tx_done;
    logic                     cmd_ok;
    adc_monitor_pkg::chan_t   chan_q;
    adc_monitor_pkg::sample_t peak_q;

    assign cmd_ok  = (rx_data >= DIGIT_FIRST) && (rx_data <= DIGIT_LAST);
    assign tx_done = tx_busy_d && !tx_busy;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state       <= ST_IDLE;
            req_pending <= 1'b0;
            tx_busy_d   <= 1'b0;
            tx_start    <= 1'b0;
        end else begin
            tx_busy_d <= tx_busy;
            tx_start  <= 1'b0;
            case (state)
                // Commands outside idle are dropped here
                ST_IDLE: begin
                    if (rx_valid && cmd_ok) begin
                        req_pending <= 1'b1;
                        state       <= ST_READ;
                    end
                end
                ST_READ: begin
                    if (cache.gnt) begin
                        req_pending <= 1'b0;
                    end
                    if (cache.rvalid) begin
                        tx_start <= 1'b1;
                        state    <= ST_SEND_HI;
                    end
                end
                ST_SEND_HI: begin
                    if (tx_done) begin
                        tx_start <= 1'b1;
                        state    <= ST_SEND_LO;
                    end
                end
                ST_SEND_LO: begin
                    if (tx_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Channel and peak payload
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && rx_valid && cmd_ok) begin
            chan_q <= adc_monitor_pkg::chan_t'(rx_data - DIGIT_FIRST);
        end
        if (state == ST_READ && cache.rvalid) begin
            peak_q <= cache.rdata;
            tx_data <= {{(16 - `SAMPLE_BITS){1'b0}}, cache.rdata[`SAMPLE_BITS-1:8]};
        end else if (state == ST_SEND_HI && tx_done) begin
            tx_data <= peak_q[7:0];
        end
    end

    assign cache.req   = req_pending;
    assign cache.op    = adc_monitor_pkg::CACHE_READ_CLEAR;
    assign cache.chan  = chan_q;
    assign cache.wdata = '0;

endmodule

// File: source/spi_adc_sampler.sv
// SPI ADC sampler framing shared chip select and clock, capturing four channels in parallel
`timescale 1ns/1ps
`include "adc_monitor_defs.svh"

module spi_adc_sampler (
    input  logic                     clk,
    input  logic                     reset_b,
    input  logic [`ADC_CHANNELS-1:0] adc_miso,
    output logic                     adc_cs_n,
    output logic                     spi_sclk,
    cache_bus_if.client              cache
);

    localparam int FRAME_TOTAL = `SPI_FRAME_CLKS + `CS_IDLE_CLKS;
    localparam int BIT_W       = $clog2(FRAME_TOTAL);
    localparam int DIV_W       = $clog2(`SPI_HALF_PERIOD + 1);

    logic [DIV_W-1:0]         div_cnt;
    logic                     phase;
    logic [BIT_W-1:0]         bit_cnt;
    logic                     half_tick;
    logic                     next_phase;
    logic [BIT_W-1:0]         next_bit;
    logic                     rise_tick;
    logic                     frame_done;
    adc_monitor_pkg::sample_t shift_q [`ADC_CHANNELS];
    adc_monitor_pkg::sample_t hold_q  [`ADC_CHANNELS];
    adc_monitor_pkg::chan_t   post_chan;
    logic                     post_busy;

    assign half_tick  = (div_cnt == DIV_W'(`SPI_HALF_PERIOD - 1));
    assign next_phase = half_tick ? ~phase : phase;

    // SPI clock index, wraps once per frame
    always_comb begin
        next_bit = bit_cnt;
        if (half_tick && phase) begin
            next_bit = (bit_cnt == BIT_W'(FRAME_TOTAL - 1)) ? '0 : bit_cnt + 1'b1;
        end
    end

    // Rising SPI edge while chip select is low
    assign rise_tick  = half_tick && !phase && (bit_cnt < BIT_W'(`SPI_FRAME_CLKS));
    // Chip select about to rise
    assign frame_done = half_tick && phase && (bit_cnt == BIT_W'(`SPI_FRAME_CLKS - 1));

    // Frame starts in the idle part so chip select is high out of reset
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            div_cnt  <= '0;
            phase    <= 1'b0;
            bit_cnt  <= BIT_W'(`SPI_FRAME_CLKS);
            adc_cs_n <= 1'b1;
            spi_sclk <= 1'b0;
        end else begin
            div_cnt  <= half_tick ? '0 : div_cnt + 1'b1;
            phase    <= next_phase;
            bit_cnt  <= next_bit;
            adc_cs_n <= (next_bit >= BIT_W'(`SPI_FRAME_CLKS));
            spi_sclk <= next_phase && (next_bit < BIT_W'(`SPI_FRAME_CLKS));
        end
    end

    // Leading bits fall out of the top, last ten remain
    always_ff @(posedge clk) begin
        if (rise_tick) begin
            for (int ch = 0; ch < `ADC_CHANNELS; ch++) begin
                shift_q[ch] <= {shift_q[ch][`SAMPLE_BITS-2:0], adc_miso[ch]};
            end
        end
        if (frame_done) begin
            hold_q <= shift_q;
        end
    end

    // Walk the channels, one cache update per grant
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            post_busy <= 1'b0;
            post_chan <= '0;
        end else if (frame_done) begin
            post_busy <= 1'b1;
            post_chan <= '0;
        end else if (post_busy && cache.gnt) begin
            if (post_chan == adc_monitor_pkg::chan_t'(`ADC_CHANNELS - 1)) begin
                post_busy <= 1'b0;
            end
            post_chan <= post_chan + 1'b1;
        end
    end

    assign cache.req   = post_busy;
    assign cache.op    = adc_monitor_pkg::CACHE_UPDATE;
    assign cache.chan  = post_chan;
    assign cache.wdata = hold_q[post_chan];

endmodule

// File: source/uart_link.sv
// UART receiver and transmitter, 8N1 at a fixed bit period
`timescale 1ns/1ps
`include "adc_monitor_defs.svh"

module uart_link (
    input  logic       clk,
    input  logic       reset_b,
    input  logic       uart_rx,
    output logic       uart_tx,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx_busy
);

    localparam int CNT_W = $clog2(`UART_BIT_CLKS);

    logic [1:0]       rx_sync;
    logic             rx_line;
    logic             rx_busy;
    logic [CNT_W-1:0] rx_wait;
    logic [3:0]       rx_bit;
    logic [7:0]       rx_shift;
    logic [9:0]       tx_shift;
    logic [CNT_W-1:0] tx_cnt;
    logic [3:0]       tx_bit;

    // Two-flop synchronizer, idles high
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx};
        end
    end
    assign rx_line = rx_sync[1];

    // rx_wait counts down to the middle of the next bit
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            rx_busy  <= 1'b0;
            rx_wait  <= '0;
            rx_bit   <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!rx_busy) begin
                if (!rx_line) begin
                    rx_busy <= 1'b1;
                    rx_wait <= CNT_W'(`UART_BIT_CLKS / 2 - 1);
                    rx_bit  <= '0;
                end
            end else if (rx_wait != '0) begin
                rx_wait <= rx_wait - 1'b1;
            end else begin
                rx_wait <= CNT_W'(`UART_BIT_CLKS - 1);
                rx_bit  <= rx_bit + 1'b1;
                if (rx_bit == 4'd0 && rx_line) begin
                    // Glitch, not a real start bit
                    rx_busy <= 1'b0;
                end else if (rx_bit == 4'd9) begin
                    rx_busy  <= 1'b0;
                    rx_valid <= rx_line;
                end
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (rx_busy && rx_wait == '0 && rx_bit >= 4'd1 && rx_bit <= 4'd8) begin
            rx_shift <= {rx_line, rx_shift[7:1]};
        end
    end
    assign rx_data = rx_shift;

    // Transmitter, frame is stop, data, start from MSB down
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            tx_busy <= 1'b0;
            tx_cnt  <= '0;
            tx_bit  <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy <= 1'b1;
                tx_cnt  <= '0;
                tx_bit  <= '0;
            end
        end else if (tx_cnt == CNT_W'(`UART_BIT_CLKS - 1)) begin
            tx_cnt <= '0;
            if (tx_bit == 4'd9) begin
                tx_busy <= 1'b0;
            end else begin
                tx_bit <= tx_bit + 1'b1;
            end
        end else begin
            tx_cnt <= tx_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            tx_shift <= {1'b1, tx_data, 1'b0};
        end else if (tx_busy && tx_cnt == CNT_W'(`UART_BIT_CLKS - 1)) begin
            tx_shift <= {1'b1, tx_shift[9:1]};
        end
    end

    assign uart_tx = tx_busy ? tx_shift[0] : 1'b1;

endmodule

// File: testbench/adc_monitor_assertions.sv
// ADC peak monitor protocol assertions, bound into the top level
`timescale 1ns/1ps

module adc_monitor_assertions (
    input logic clk,
    input logic reset_b,
    input logic adc_cs_n,
    input logic spi_sclk,
    input logic uart_tx,
    input logic sampler_gnt,
    input logic query_gnt,
    input logic frame_done,
    input logic post_busy
);

    // SPI clock parks low between frames
    sclk_idle_low: assert property (@(posedge clk) disable iff (!reset_b)
        adc_cs_n |-> !spi_sclk)
        else $error("spi_sclk high while adc_cs_n is high");

    // Arbiter grants one client at a time
    one_grant: assert property (@(posedge clk) disable iff (!reset_b)
        !(sampler_gnt && query_gnt))
        else $error("both cache clients granted in one cycle");

    uart_idle_after_reset: assert property (@(posedge clk)
        $rose(reset_b) |-> uart_tx)
        else $error("uart_tx not idle high after reset");

    // All four updates of a frame are posted before the next one ends
    no_frame_overrun: assert property (@(posedge clk) disable iff (!reset_b)
        frame_done |-> !post_busy)
        else $error("new frame while cache updates still pending");

endmodule

bind adc_monitor_top adc_monitor_assertions i_adc_monitor_assertions (
    .clk         (clk),
    .reset_b     (reset_b),
    .adc_cs_n    (adc_cs_n),
    .spi_sclk    (spi_sclk),
    .uart_tx     (uart_tx),
    .sampler_gnt (sampler_bus.gnt),
    .query_gnt   (query_bus.gnt),
    .frame_done  (i_spi_adc_sampler.frame_done),
    .post_busy   (i_spi_adc_sampler.post_busy)
);

// File: testbench/adc_monitor_tb.sv
// ADC peak monitor testbench replaying ADC frames and host queries from a data file
`timescale 1ns/1ps
`include "adc_monitor_defs.svh"

module adc_monitor_tb;

    localparam string DATA_FILE = "testbench/adc_monitor_testdata.txt";
    localparam int    BYTE_CLKS = 10 * `UART_BIT_CLKS;
    localparam int    SPI_CLKS  = 2 * `SPI_HALF_PERIOD;

    logic                     clk;
    logic                     reset_b  = 1'b0;
    logic [`ADC_CHANNELS-1:0] adc_miso = '0;
    logic                     uart_rx  = 1'b1;
    logic                     adc_cs_n;
    logic                     spi_sclk;
    logic                     uart_tx;

    // Replay records
    byte         rec_kind [$];
    logic [31:0] rec_a [$];
    logic [31:0] rec_b [$];
    logic [31:0] rec_c [$];
    logic [31:0] rec_d [$];

    // ADC model state and counter handshake with the main process
    adc_monitor_pkg::sample_t pend_vals [`ADC_CHANNELS];
    logic [11:0]              adc_word  [`ADC_CHANNELS];
    int                       req_count   = 0;
    int                       taken_count = 0;
    int                       frame_count = 0;
    int                       bit_idx     = 0;
    logic                     cs_d;
    logic                     sclk_d;

    int cycle_count   = 0;
    int cycle_limit   = 0;
    bit fail_reported = 0;
    bit pass_reported = 0;

    adc_monitor_top i_adc_monitor_top (
        .clk      (clk),
        .reset_b  (reset_b),
        .adc_miso (adc_miso),
        .uart_rx  (uart_rx),
        .adc_cs_n (adc_cs_n),
        .spi_sclk (spi_sclk),
        .uart_tx  (uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        fail_reported = 1;
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_peak(input string name, input adc_monitor_pkg::sample_t exp,
                              input adc_monitor_pkg::sample_t got);
        if (got !== exp)
            fail_now($sformatf("mismatch %s: expected %h, got %h", name, exp, got));
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp)
            fail_now($sformatf("mismatch %s: expected %h, got %h", name, exp, got));
    endtask

    task automatic check_level(input string name, input logic exp, input logic got);
        if (got !== exp)
            fail_now($sformatf("mismatch %s: expected %h, got %h", name, exp, got));
    endtask

    task automatic check_count(input string name, input int exp, input int got);
        if (got != exp)
            fail_now($sformatf("mismatch %s: expected %h, got %h", name, exp, got));
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit)
            fail_now("timeout, the run exceeded its cycle limit");
    end

    // ADC model loads a word at chip select rise and shifts on falling SPI clock
    always @(posedge clk) begin
        if (!reset_b) begin
            cs_d   <= 1'b1;
            sclk_d <= 1'b0;
            for (int ch = 0; ch < `ADC_CHANNELS; ch++)
                adc_word[ch] <= '0;
        end else begin
            cs_d   <= adc_cs_n;
            sclk_d <= spi_sclk;
            if (!cs_d && adc_cs_n) begin
                frame_count <= frame_count + 1;
                for (int ch = 0; ch < `ADC_CHANNELS; ch++) begin
                    // Zero frames leave the peaks alone
                    adc_word[ch] <= (req_count != taken_count) ? {2'b00, pend_vals[ch]} : '0;
                end
                if (req_count != taken_count)
                    taken_count <= taken_count + 1;
            end
            if (cs_d && !adc_cs_n) begin
                for (int ch = 0; ch < `ADC_CHANNELS; ch++)
                    adc_miso[ch] <= adc_word[ch][11];
                bit_idx <= 1;
            end else if (sclk_d && !spi_sclk && !adc_cs_n && bit_idx < 12) begin
                for (int ch = 0; ch < `ADC_CHANNELS; ch++)
                    adc_miso[ch] <= adc_word[ch][11-bit_idx];
                bit_idx <= bit_idx + 1;
            end
        end
    end

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rx <= frame[i];
            repeat (`UART_BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    // Returns in the middle of the stop bit
    task automatic recv_byte(output logic [7:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        while (uart_tx !== 1'b0) begin
            @(posedge clk);
            waited++;
            if (waited > 4 * BYTE_CLKS)
                fail_now("no reply byte arrived on uart_tx");
        end
        repeat (`UART_BIT_CLKS / 2) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
            repeat (`UART_BIT_CLKS) @(posedge clk);
            data[i] = uart_tx;
        end
        repeat (`UART_BIT_CLKS) @(posedge clk);
        if (uart_tx !== 1'b1)
            fail_now("reply byte has no stop bit");
    endtask

    task automatic expect_silence(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            if (uart_tx !== 1'b1)
                fail_now("unexpected reply on uart_tx");
        end
    endtask

    task automatic measure_frame();
        int   low_clks;
        int   high_clks;
        int   rises;
        logic sclk_prev;
        low_clks  = 0;
        high_clks = 0;
        rises     = 0;
        sclk_prev = 1'b0;
        @(posedge clk);
        while (adc_cs_n !== 1'b0) @(posedge clk);
        while (adc_cs_n === 1'b0) begin
            low_clks++;
            if (spi_sclk && !sclk_prev)
                rises++;
            sclk_prev = spi_sclk;
            @(posedge clk);
        end
        while (adc_cs_n === 1'b1) begin
            high_clks++;
            @(posedge clk);
        end
        check_count("adc_cs_n low cycles", `SPI_FRAME_CLKS * SPI_CLKS, low_clks);
        check_count("adc_cs_n high cycles", `CS_IDLE_CLKS * SPI_CLKS, high_clks);
        check_count("spi_sclk rises per frame", `SPI_FRAME_CLKS, rises);
    endtask

    initial begin
        int                       fd;
        int                       n;
        int                       fc;
        int                       seed;
        int                       chan;
        string                    line;
        logic [31:0]              a;
        logic [31:0]              b;
        logic [31:0]              c;
        logic [31:0]              d;
        logic [7:0]               hi;
        logic [7:0]               lo;
        adc_monitor_pkg::sample_t model [`ADC_CHANNELS];

        seed = 32'h9101bfde;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0)
            fail_now("cannot open the test data file");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                a = '0;
                b = '0;
                c = '0;
                d = '0;
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d);
                rec_kind.push_back(line.getc(0));
                rec_a.push_back(a);
                rec_b.push_back(b);
                rec_c.push_back(c);
                rec_d.push_back(d);
            end
        end
        $fclose(fd);
        cycle_limit = (rec_kind.size() + 1) * 1000;
        for (int ch = 0; ch < `ADC_CHANNELS; ch++)
            model[ch] = '0;

        repeat (5) @(posedge clk);
        reset_b <= 1'b1;
        @(posedge clk);
        check_level("adc_cs_n", 1'b1, adc_cs_n);
        check_level("spi_sclk", 1'b0, spi_sclk);
        check_level("uart_tx", 1'b1, uart_tx);
        measure_frame();

        for (int r = 0; r < rec_kind.size(); r++) begin
            repeat ($random(seed) & 32'h7) @(posedge clk);
            case (rec_kind[r])
                "F": begin
                    pend_vals[0] <= rec_a[r][9:0];
                    pend_vals[1] <= rec_b[r][9:0];
                    pend_vals[2] <= rec_c[r][9:0];
                    pend_vals[3] <= rec_d[r][9:0];
                    req_count    <= req_count + 1;
                    if (rec_a[r][9:0] > model[0])
                        model[0] = rec_a[r][9:0];
                    if (rec_b[r][9:0] > model[1])
                        model[1] = rec_b[r][9:0];
                    if (rec_c[r][9:0] > model[2])
                        model[2] = rec_c[r][9:0];
                    if (rec_d[r][9:0] > model[3])
                        model[3] = rec_d[r][9:0];
                    @(posedge clk);
                    while (taken_count != req_count) @(posedge clk);
                    // Wait out the frame carrying these values and its cache updates
                    fc = frame_count;
                    while (frame_count == fc) @(posedge clk);
                    repeat (16) @(posedge clk);
                end
                "Q": begin
                    chan = int'(rec_a[r][7:0]) - 8'h31;
                    check_peak("model peak", rec_b[r][9:0], model[chan]);
                    fork
                        send_byte(rec_a[r][7:0]);
                        recv_byte(hi);
                    join
                    if (rec_c[r][7:0] != 8'h00) begin
                        fork
                            recv_byte(lo);
                            send_byte(rec_c[r][7:0]);
                        join
                    end else begin
                        recv_byte(lo);
                    end
                    check_byte("uart_tx high byte", {6'b0, model[chan][9:8]}, hi);
                    check_byte("uart_tx low byte", model[chan][7:0], lo);
                    model[chan] = '0;
                    if (rec_c[r][7:0] != 8'h00)
                        expect_silence(2 * BYTE_CLKS);
                end
                "X": begin
                    fork
                        send_byte(rec_a[r][7:0]);
                        expect_silence(3 * BYTE_CLKS);
                    join
                end
                default: fail_now("unknown record kind in the test data");
            endcase
        end

        if (!fail_reported) begin
            pass_reported = 1;
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    final begin
        if (!pass_reported && !fail_reported)
            $display("TESTS FAILED");
    end

endmodule

// File: testbench/adc_monitor_testdata.txt
# F ch0 ch1 ch2 ch3 : one ADC frame, 10-bit values in hex
# Q cmd peak drop : command byte, expected peak, byte sent during the answer (00 for none)
# X byte : byte that must draw no answer
F 100 020 3ff 001
F 0a5 1c0 200 002
F 050 1ff 3fe 000
Q 31 100 00
Q 31 000 00
Q 32 1ff 00
F 3ff 000 000 000
Q 33 3ff 00
X 35
X 41
Q 34 002 31
Q 31 3ff 00
X 30
Q 32 000 00
